// File: hw/glueAddressDecode.sv
// Bus cycle address decoder

`timescale 1ns/100ps

module glueAddressDecode (
    input  logic        clk40,
    input  logic        rst,
    input  logic        tsn,
    input  logic        ovl,
    input  logic [1:0]  tt,
    input  logic [31:1] addr,
    input  logic        cycleEnd,
    output logic        romEnn,
    output logic        ramSpacen,
    output logic        regSpacen,
    output logic        ciaCs0n,
    output logic        ciaCs1n,
    output logic        bufEnn,
    output logic        portSize,
    output logic        romSel,
    output logic        chipSel,
    output logic        ciaSel,
    output logic        cycleActive
);

    import gluePkg::*;

    busAddr_u   busAddr;
    logic [7:0] bank;
    logic       normalCycle;
    logic       romHit;
    logic       ramHit;
    logic       regHit;
    logic       ciaHit;
    logic       startCycle;

    //////////////////////////////
    // Combinational decode
    //////////////////////////////

    assign busAddr = addr;
    assign bank    = busAddr.chip.bank;

    // Normal transfer type, low 16 MB only
    assign normalCycle = (tt == TT_NORMAL) && (busAddr.chip.upper == 8'h00);

    // Kickstart window, or its shadow at the bottom during overlay
    assign romHit = normalCycle &&
                    (((bank >= ROM_BANK_LO) && ({1'b0, bank} <= {1'b0, ROM_BANK_HI})) ||
                     (ovl && (bank <= OVL_BANK_HI)));

    // Chip RAM hidden by the overlay
    assign ramHit = normalCycle && !ovl && (bank <= CHIPRAM_BANK_HI);

    assign regHit = normalCycle && (bank == CHIPREG_BANK);
    assign ciaHit = normalCycle && (bank == CIA_BANK);

    // New cycle only from idle
    assign startCycle = !tsn && !cycleActive;

    //////////////////////////////
    // Registered selects
    //////////////////////////////

    always_ff @(posedge clk40) begin
        if (rst) begin
            romEnn      <= 1'b1;
            ramSpacen   <= 1'b1;
            regSpacen   <= 1'b1;
            ciaCs0n     <= 1'b1;
            ciaCs1n     <= 1'b1;
            bufEnn      <= 1'b1;
            portSize    <= 1'b0;
            romSel      <= 1'b0;
            chipSel     <= 1'b0;
            ciaSel      <= 1'b0;
            cycleActive <= 1'b0;
        end else if (startCycle) begin
            // Pin selects, active low
            romEnn      <= !romHit;
            ramSpacen   <= !ramHit;
            regSpacen   <= !regHit;
            // A12 and A13 pick the CIA, both may be low
            ciaCs0n     <= !(ciaHit && !busAddr.cia.ciaASel);
            ciaCs1n     <= !(ciaHit && !busAddr.cia.ciaBSel);
            // Data buffers serve the chip bus only
            bufEnn      <= !(ramHit || regHit);
            // 16-bit port for CIA and custom registers
            portSize    <= ciaHit || regHit;
            // Space flags for the acknowledge timing
            romSel      <= romHit;
            chipSel     <= ramHit || regHit;
            ciaSel      <= ciaHit;
            cycleActive <= 1'b1;
        end else if (cycleEnd) begin
            // Release everything the edge after tackn
            romEnn      <= 1'b1;
            ramSpacen   <= 1'b1;
            regSpacen   <= 1'b1;
            ciaCs0n     <= 1'b1;
            ciaCs1n     <= 1'b1;
            bufEnn      <= 1'b1;
            portSize    <= 1'b0;
            romSel      <= 1'b0;
            chipSel     <= 1'b0;
            ciaSel      <= 1'b0;
            cycleActive <= 1'b0;
        end
    end

endmodule

// File: hw/glueCiaTiming.sv
// CIA clock divider

`timescale 1ns/100ps

module glueCiaTiming (
    input  logic clk40,
    input  logic rst,
    output logic ciaClk,
    output logic ciaEnable
);

    import gluePkg::*;

    localparam int HALF_W = $clog2(CIA_HALF);

    logic [HALF_W-1:0] halfCnt;
    logic              halfDone;

    //////////////////////////////
    // Half-period counter
    //////////////////////////////

    // Last clk40 cycle of a ciaClk half
    assign halfDone = (halfCnt == HALF_W'(CIA_HALF - 1));

    always_ff @(posedge clk40) begin
        if (rst) begin
            halfCnt <= '0;
        end else if (halfDone) begin
            halfCnt <= '0;
        end else begin
            halfCnt <= halfCnt + 1'b1;
        end
    end

    //////////////////////////////
    // Clock and enable
    //////////////////////////////

    // Free running from reset, no link to bus cycles
    always_ff @(posedge clk40) begin
        if (rst) begin
            ciaClk    <= 1'b0;
            ciaEnable <= 1'b0;
        end else begin
            ciaEnable <= 1'b0;
            if (halfDone) begin
                ciaClk <= !ciaClk;
                // High half ending, so ciaClk falls here
                // CIA transfer completes on this edge
                ciaEnable <= ciaClk;
            end
        end
    end

endmodule

// File: hw/gluePkg.sv
// Local bus glue definitions

package gluePkg;

    //////////////////////////////
    // Address map
    //////////////////////////////

    // Kickstart ROM window in A23:16
    localparam logic [7:0] ROM_BANK_LO     = 8'hF8;
    localparam logic [7:0] ROM_BANK_HI     = 8'hFF;

    // Low ROM shadow while overlay is set
    localparam logic [7:0] OVL_BANK_HI     = 8'h07;

    // Top bank of chip RAM
    localparam logic [7:0] CHIPRAM_BANK_HI = 8'h1F;

    // Both CIAs share one bank
    localparam logic [7:0] CIA_BANK        = 8'hBF;

    // Custom chip registers
    localparam logic [7:0] CHIPREG_BANK    = 8'hDF;

    //////////////////////////////
    // Wait states
    //////////////////////////////

    // Counted from the tsn edge to the tackn edge
    localparam int ROM_WAIT      = 4;
    localparam int CHIP_WAIT     = 6;
    // Fast answer for nothing mapped
    localparam int UNMAPPED_WAIT = 2;

    // clk40 cycles per ciaClk half-period
    localparam int CIA_HALF      = 10;

    // Only normal accesses are decoded
    localparam logic [1:0] TT_NORMAL = 2'b00;

    //////////////////////////////
    // Bus address views
    //////////////////////////////

    // Word address A31:1, read as a CIA access or as a chip-space access
    typedef union packed {
        struct packed {
            logic [17:0] upper;    // A31:14
            logic        ciaBSel;  // A13, low selects CIA-B
            logic        ciaASel;  // A12, low selects CIA-A
            logic [3:0]  regIdx;   // A11:8
            logic [6:0]  rest;     // A7:1
        } cia;
        struct packed {
            logic [7:0]  upper;    // A31:24
            logic [7:0]  bank;     // A23:16
            logic [14:0] offset;   // A15:1
        } chip;
    } busAddr_u;

endpackage

// File: hw/glueTop.sv
// Local bus glue top level

`timescale 1ns/100ps

module glueTop (
    input  logic        clk40,
    input  logic        rst,
    input  logic        tsn,
    input  logic        ovl,
    input  logic [1:0]  tt,
    input  logic [31:1] addr,
    output logic        romEnn,
    output logic        ramSpacen,
    output logic        regSpacen,
    output logic        ciaCs0n,
    output logic        ciaCs1n,
    output logic        bufEnn,
    output logic        portSize,
    output logic        ciaClk,
    output logic        tackn
);

    // Space flags between decode and acknowledge
    logic romSel;
    logic chipSel;
    logic ciaSel;
    logic cycleActive;
    logic cycleEnd;
    // Falling ciaClk strobe
    logic ciaEnable;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    glueAddressDecode addrDecode0 (
        .clk40       (clk40),
        .rst         (rst),
        .tsn         (tsn),
        .ovl         (ovl),
        .tt          (tt),
        .addr        (addr),
        .cycleEnd    (cycleEnd),
        .romEnn      (romEnn),
        .ramSpacen   (ramSpacen),
        .regSpacen   (regSpacen),
        .ciaCs0n     (ciaCs0n),
        .ciaCs1n     (ciaCs1n),
        .bufEnn      (bufEnn),
        .portSize    (portSize),
        .romSel      (romSel),
        .chipSel     (chipSel),
        .ciaSel      (ciaSel),
        .cycleActive (cycleActive)
    );

    //////////////////////////////
    // CIA clock
    //////////////////////////////

    glueCiaTiming ciaTiming0 (
        .clk40     (clk40),
        .rst       (rst),
        .ciaClk    (ciaClk),
        .ciaEnable (ciaEnable)
    );

    //////////////////////////////
    // Transfer acknowledge
    //////////////////////////////

    glueTransferAck transferAck0 (
        .clk40       (clk40),
        .rst         (rst),
        .cycleActive (cycleActive),
        .romSel      (romSel),
        .chipSel     (chipSel),
        .ciaSel      (ciaSel),
        .ciaEnable   (ciaEnable),
        .tackn       (tackn),
        .cycleEnd    (cycleEnd)
    );

endmodule

// File: hw/glueTransferAck.sv
// Transfer acknowledge timing

`timescale 1ns/100ps

module glueTransferAck (
    input  logic clk40,
    input  logic rst,
    input  logic cycleActive,
    input  logic romSel,
    input  logic chipSel,
    input  logic ciaSel,
    input  logic ciaEnable,
    output logic tackn,
    output logic cycleEnd
);

    import gluePkg::*;

    // Chip space has the longest fixed wait
    localparam int CNT_W = $clog2(CHIP_WAIT);

    logic             prevActive;
    logic             cycleStart;
    logic             waiting;
    logic             ciaWait;
    logic [CNT_W-1:0] waitCnt;
    logic [CNT_W-1:0] loadCnt;
    logic             ackNow;

    //////////////////////////////
    // Wait selection
    //////////////////////////////

    // First cycle after the decoder latched the address
    assign cycleStart = cycleActive && !prevActive;

    // Two cycles spent before the count starts
    // One for the decode, one for the load
    always_comb begin
        if (romSel) begin
            loadCnt = CNT_W'(ROM_WAIT - 2);
        end else if (chipSel) begin
            loadCnt = CNT_W'(CHIP_WAIT - 2);
        end else begin
            loadCnt = CNT_W'(UNMAPPED_WAIT - 2);
        end
    end

    // CIA waits on the falling ciaClk, others on the counter
    assign ackNow = ciaWait ? ciaEnable : (waitCnt == '0);

    //////////////////////////////
    // Acknowledge
    //////////////////////////////

    always_ff @(posedge clk40) begin
        if (rst) begin
            prevActive <= 1'b0;
            waiting    <= 1'b0;
            ciaWait    <= 1'b0;
            waitCnt    <= '0;
            tackn      <= 1'b1;
        end else begin
            prevActive <= cycleActive;
            // One-cycle low pulse
            tackn      <= 1'b1;
            if (cycleStart) begin
                waiting <= 1'b1;
                ciaWait <= ciaSel;
                waitCnt <= loadCnt;
            end else if (waiting) begin
                if (ackNow) begin
                    tackn   <= 1'b0;
                    waiting <= 1'b0;
                end else if (!ciaWait) begin
                    waitCnt <= waitCnt - 1'b1;
                end
            end
        end
    end

    // Tells the decoder to drop its selects
    assign cycleEnd = !tackn;

endmodule

// File: run.sh
#!/bin/sh
# Build and run the bus glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module glueTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VglueTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// File: verif/glueAck_assert.sv
// Acknowledge block checks

`timescale 1ns/100ps

module glueAckAssert (
    input logic clk40,
    input logic rst,
    input logic tackn,
    input logic cycleActive,
    input logic romSel,
    input logic chipSel,
    input logic ciaSel
);

    // Acknowledge is a single-cycle pulse
    ackOneCycle: assert property (@(posedge clk40) disable iff (rst) !tackn |=> tackn)
        else $error("tackn low for two cycles in a row");

    // No acknowledge on an idle bus
    ackInCycle: assert property (@(posedge clk40) disable iff (rst) !tackn |-> cycleActive)
        else $error("tackn low with no active cycle");

    // Spaces are exclusive
    oneSpace: assert property (@(posedge clk40) disable iff (rst)
                               $onehot0({romSel, chipSel, ciaSel}))
        else $error("more than one space flag set");

endmodule

bind glueTransferAck glueAckAssert ackAssert0 (
    .clk40       (clk40),
    .rst         (rst),
    .tackn       (tackn),
    .cycleActive (cycleActive),
    .romSel      (romSel),
    .chipSel     (chipSel),
    .ciaSel      (ciaSel)
);

// File: verif/glueTb.sv
// Local bus glue testbench

`timescale 1ns/100ps

module glueTb;

    import gluePkg::*;

    localparam int MAX_CASES    = 64;
    localparam int RESET_CYCLES = 8;
    localparam int CIA_MAX      = 2 * CIA_HALF + 1;
    // romEnn ramSpacen regSpacen ciaCs0n ciaCs1n bufEnn portSize
    localparam logic [6:0] IDLE_SEL = 7'b1111110;

    logic        clk40;
    logic        rst;
    logic        tsn;
    logic        ovl;
    logic [1:0]  tt;
    logic [31:1] addr;
    logic        romEnn;
    logic        ramSpacen;
    logic        regSpacen;
    logic        ciaCs0n;
    logic        ciaCs1n;
    logic        bufEnn;
    logic        portSize;
    logic        ciaClk;
    logic        tackn;

    // Case table from the data file
    logic [31:0] caseAddr  [MAX_CASES];
    logic [1:0]  caseTt    [MAX_CASES];
    logic        caseOvl   [MAX_CASES];
    logic [6:0]  caseSel   [MAX_CASES];
    logic [7:0]  caseClass [MAX_CASES];
    int          numCases    = 0;
    logic        casesLoaded = 1'b0;

    // ciaClk seen at the last three samples
    logic clkNow;
    logic clkOld;
    logic clkOlder;

    glueTop dut0 (
        .clk40     (clk40),
        .rst       (rst),
        .tsn       (tsn),
        .ovl       (ovl),
        .tt        (tt),
        .addr      (addr),
        .romEnn    (romEnn),
        .ramSpacen (ramSpacen),
        .regSpacen (regSpacen),
        .ciaCs0n   (ciaCs0n),
        .ciaCs1n   (ciaCs1n),
        .bufEnn    (bufEnn),
        .portSize  (portSize),
        .ciaClk    (ciaClk),
        .tackn     (tackn)
    );

    initial begin
        clk40 = 1'b0;
        forever #5 clk40 = ~clk40;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic abortRun();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkSelects(logic [6:0] expected);
        checkValue("romEnn", 32'(expected[6]), 32'(romEnn));
        checkValue("ramSpacen", 32'(expected[5]), 32'(ramSpacen));
        checkValue("regSpacen", 32'(expected[4]), 32'(regSpacen));
        checkValue("ciaCs0n", 32'(expected[3]), 32'(ciaCs0n));
        checkValue("ciaCs1n", 32'(expected[2]), 32'(ciaCs1n));
        checkValue("bufEnn", 32'(expected[1]), 32'(bufEnn));
        checkValue("portSize", 32'(expected[0]), 32'(portSize));
    endtask

    // Sample 1 ns after the edge, inputs change at the same point
    task automatic nextCycle();
        @(posedge clk40);
        #1;
        clkOlder = clkOld;
        clkOld   = clkNow;
        clkNow   = ciaClk;
    endtask

    task automatic loadCases();
        int          fd;
        int          count;
        string       line;
        logic [31:0] a;
        logic [1:0]  t;
        logic        o;
        logic [6:0]  s;
        logic [7:0]  cls;
        fd = $fopen("verif/glue_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file verif/glue_cases.txt");
            abortRun();
        end
        while ($fgets(line, fd) != 0) begin
            // Skip comments and blank lines
            if (line.len() > 1 && line.getc(0) != "#" && numCases < MAX_CASES) begin
                count = $sscanf(line, "%h %b %b %b %s", a, t, o, s, cls);
                if (count == 5) begin
                    caseAddr[numCases]  = a;
                    caseTt[numCases]    = t;
                    caseOvl[numCases]   = o;
                    caseSel[numCases]   = s;
                    caseClass[numCases] = cls;
                    numCases++;
                end
            end
        end
        $fclose(fd);
        if (numCases == 0) begin
            $display("The case file holds no bus cycles");
            abortRun();
        end
        casesLoaded = 1'b1;
    endtask

    //////////////////////////////
    // One bus cycle
    //////////////////////////////

    task automatic runCase(int idx);
        int gap;
        int latency;
        gap = int'($urandom % 6);
        repeat (gap) begin
            nextCycle();
            checkValue("tackn", 32'd1, 32'(tackn));
        end
        // Start strobe, one cycle wide
        tsn  = 1'b0;
        addr = caseAddr[idx][31:1];
        tt   = caseTt[idx];
        ovl  = caseOvl[idx];
        nextCycle();
        tsn     = 1'b1;
        latency = 0;
        // Selects hold until tackn
        while (tackn) begin
            checkSelects(caseSel[idx]);
            if (latency >= CIA_MAX) begin
                $display("No tackn for case %0d at address %h", idx, caseAddr[idx]);
                abortRun();
            end
            nextCycle();
            latency++;
        end
        checkSelects(caseSel[idx]);
        case (caseClass[idx])
            "R": checkValue("romLatency", ROM_WAIT, latency);
            "C": checkValue("chipLatency", CHIP_WAIT, latency);
            "U": checkValue("unmappedLatency", UNMAPPED_WAIT, latency);
            "A": begin
                checkValue("ciaLatencyInRange", 32'd1,
                           32'(latency >= 2 && latency <= CIA_MAX));
                // ciaClk fell on the edge before tackn
                checkValue("ciaClkBeforeTackn", 32'd0, 32'(clkOld));
                checkValue("ciaClkBeforeFall", 32'd1, 32'(clkOlder));
            end
            default: begin
                $display("Unknown wait class in case %0d of the case file", idx);
                abortRun();
            end
        endcase
        // Release on the edge after tackn
        nextCycle();
        checkValue("tackn", 32'd1, 32'(tackn));
        checkSelects(IDLE_SEL);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rst  = 1'b1;
        tsn  = 1'b1;
        ovl  = 1'b0;
        tt   = 2'b00;
        addr = '0;
        void'($urandom(32'h335d2ccb));
        loadCases();
        repeat (RESET_CYCLES) nextCycle();
        // Reset state
        checkSelects(IDLE_SEL);
        checkValue("tackn", 32'd1, 32'(tackn));
        checkValue("ciaClk", 32'd0, 32'(ciaClk));
        rst = 1'b0;
        // Idle bus, no acknowledge
        repeat (4) begin
            nextCycle();
            checkValue("tackn", 32'd1, 32'(tackn));
        end
        for (int i = 0; i < numCases; i++) begin
            runCase(i);
        end
        $display("TEST OK");
        $finish;
    end

    // Watchdog sized from the case count
    initial begin
        wait (casesLoaded);
        repeat (RESET_CYCLES + numCases * (2 * CIA_HALF + 10)) @(posedge clk40);
        $display("Timeout: the bus cycles did not finish in the expected time");
        abortRun();
    end

endmodule

// File: verif/glue_cases.txt
# addr(byte, hex) tt ovl selects class(R rom, C chip, U unmapped, A cia)
# selects: romEnn ramSpacen regSpacen ciaCs0n ciaCs1n bufEnn portSize
00f80000 00 0 0111110 R
00fc1234 00 0 0111110 R
00fffffe 00 0 0111110 R
00000000 00 1 0111110 R
0007fffe 00 1 0111110 R
00f80000 00 1 0111110 R
00000000 00 0 1011100 C
0007fffe 00 0 1011100 C
001ffffe 00 0 1011100 C
00dff000 00 0 1101101 C
00dff180 00 0 1101101 C
00dff09a 00 1 1101101 C
00bfe001 00 0 1110111 A
00bfd000 00 0 1111011 A
00bfc000 00 0 1110011 A
00bff000 00 0 1111111 A
00bfe101 00 1 1110111 A
00080000 00 1 1111110 U
00200000 00 0 1111110 U
00c00000 00 0 1111110 U
00f70000 00 0 1111110 U
01000000 00 0 1111110 U
fff80000 00 0 1111110 U
00f80000 01 0 1111110 U
00000000 10 0 1111110 U
00bfe001 11 0 1111110 U

// File: verilog.f
hw/gluePkg.sv
hw/glueAddressDecode.sv
hw/glueCiaTiming.sv
hw/glueTransferAck.sv
hw/glueTop.sv
verif/glueAck_assert.sv
verif/glueTb.sv
